// File: Makefile
# Verilator build and run of the hawk traffic path testbench

VERILATOR ?= verilator
TOP       ?= tb_hacd_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: hacd_bus_pkg.sv
//////////////////////////////
// bus types of the hawk traffic path
// memory request and response words
// source tag of an issued request
// physical frame number
//////////////////////////////
`default_nettype none

package hacd_bus_pkg;

   import hacd_cfg_pkg::*;

   //////////////////////////////
   // request / response channels
   //////////////////////////////

   // one word per request, no bursts
   typedef struct packed {
      logic              wr;    // 1 write, 0 read
      logic [ADDR_W-1:0] addr;  // byte address
      logic [DATA_W-1:0] data;  // write data, don't care on reads
   } mem_req_t;

   // every request gets one response back, writes too
   typedef struct packed {
      logic [DATA_W-1:0] data;  // read data
   } mem_rsp_t;

   //////////////////////////////
   // arbitration and translation
   //////////////////////////////

   // who issued a request on the shared memory port
   typedef enum logic {
      SRC_HAWK = 1'b0,  // free-list init writer
      SRC_CPU  = 1'b1   // forwarded cpu traffic
   } src_tag_t;

   // physical frame number, upper address bits
   typedef logic [ADDR_W-PAGE_BITS-1:0] frame_t;

endpackage

`default_nettype wire

// File: hacd_cfg_pkg.sv
//////////////////////////////
// configuration constants of the hawk traffic path
// address and data widths
// tracked page window and frame allocation base
// free-list region and queue depths
//////////////////////////////
`default_nettype none

package hacd_cfg_pkg;

   //////////////////////////////
   // bus widths
   //////////////////////////////
   localparam int unsigned ADDR_W     = 32;  // byte address
   localparam int unsigned DATA_W     = 64;  // one data word per request
   localparam int unsigned LINE_BYTES = 8;   // bytes per data word

   //////////////////////////////
   // page window
   //////////////////////////////
   localparam int unsigned PAGE_BITS  = 12;  // 4k pages
   localparam int unsigned VPN_W      = 4;   // tracked page index
   localparam int unsigned NUM_PAGES  = 16;  // 2**VPN_W pages
   // the window is every address with zeros above PAGE_BITS+VPN_W
   localparam int unsigned FRAME_BASE = 64;  // first frame handed out

   //////////////////////////////
   // free-list region and depths
   //////////////////////////////
   localparam logic [ADDR_W-1:0] LIST_BASE = 32'h0008_0000;  // outside window and frames
   localparam int unsigned LIST_LINES  = 8;  // words zeroed after reset
   localparam int unsigned TAG_DEPTH   = 4;  // max outstanding mem requests
   localparam int unsigned CPU_Q_DEPTH = 2;  // cpu request queue

endpackage

`default_nettype wire

// File: hacd_core.sv
//////////////////////////////
// hawk compression core, traffic path
// init writer, cpu stall unit, attribute table
// and memory port arbiter
//////////////////////////////
`default_nettype none

module hacd_core (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   hawk_inactive_i,
   // cpu side
   input  hacd_bus_pkg::mem_req_t cpu_req_i,
   input  logic                   cpu_req_valid_i,
   output logic                   cpu_req_ready_o,
   output hacd_bus_pkg::mem_rsp_t cpu_rsp_o,
   output logic                   cpu_rsp_valid_o,
   input  logic                   cpu_rsp_ready_i,
   // memory controller side
   output hacd_bus_pkg::mem_req_t mc_req_o,
   output logic                   mc_req_valid_o,
   input  logic                   mc_req_ready_i,
   input  hacd_bus_pkg::mem_rsp_t mc_rsp_i,
   input  logic                   mc_rsp_valid_i,
   output logic                   mc_rsp_ready_o,
   output logic                   init_done_o
);

   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   mem_req_t           hawk_req, stall_req;           // master requests
   logic               hawk_valid, hawk_ready, hawk_rsp_valid;
   logic               stall_valid, stall_ready;
   logic [VPN_W-1:0]   lkup_vpn;                      // stall unit to table
   logic               lkup_hit, alloc;
   frame_t             lkup_frame;

   hawk_list_init u_hawk_list_init (
      .clk_i (clk_i), .arst_n_i (arst_n_i), .hawk_inactive_i (hawk_inactive_i),
      .req_o (hawk_req), .req_valid_o (hawk_valid), .req_ready_i (hawk_ready),
      .rsp_valid_i (hawk_rsp_valid), .init_done_o (init_done_o)
   );

   hawk_cpu_stall u_hawk_cpu_stall (
      .clk_i (clk_i), .arst_n_i (arst_n_i), .hawk_inactive_i (hawk_inactive_i),
      .init_done_i (init_done_o),
      .cpu_req_i (cpu_req_i), .cpu_req_valid_i (cpu_req_valid_i),
      .cpu_req_ready_o (cpu_req_ready_o),
      .fwd_req_o (stall_req), .fwd_valid_o (stall_valid), .fwd_ready_i (stall_ready),
      .lookup_vpn_o (lkup_vpn), .hit_i (lkup_hit), .frame_i (lkup_frame), .alloc_o (alloc)
   );

   hawk_att_table u_hawk_att_table (
      .clk_i (clk_i), .arst_n_i (arst_n_i), .lookup_vpn_i (lkup_vpn),
      .hit_o (lkup_hit), .frame_o (lkup_frame), .alloc_i (alloc)
   );

   hawk_mc_arbiter u_hawk_mc_arbiter (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .hawk_req_i (hawk_req), .hawk_valid_i (hawk_valid), .hawk_ready_o (hawk_ready),
      .hawk_rsp_valid_o (hawk_rsp_valid),
      .cpu_req_i (stall_req), .cpu_valid_i (stall_valid), .cpu_ready_o (stall_ready),
      .mc_req_o (mc_req_o), .mc_req_valid_o (mc_req_valid_o), .mc_req_ready_i (mc_req_ready_i),
      .mc_rsp_i (mc_rsp_i), .mc_rsp_valid_i (mc_rsp_valid_i), .mc_rsp_ready_o (mc_rsp_ready_o),
      .cpu_rsp_o (cpu_rsp_o), .cpu_rsp_valid_o (cpu_rsp_valid_o),
      .cpu_rsp_ready_i (cpu_rsp_ready_i)
   );

endmodule

`default_nettype wire

// File: hawk_att_table.sv
//////////////////////////////
// page attribute table
// valid bit and frame per tracked page
// free frame pointer, first-touch allocation
//////////////////////////////
`default_nettype none

module hawk_att_table (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic [hacd_cfg_pkg::VPN_W-1:0] lookup_vpn_i,
   output logic                           hit_o,
   output hacd_bus_pkg::frame_t           frame_o,
   input  logic                           alloc_i
);

   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   logic [NUM_PAGES-1:0] valid_q;                // page mapped
   frame_t               frame_mem [NUM_PAGES];  // frame per page
   frame_t               free_q;                 // next free frame

   //////////////////////////////
   // lookup, same cycle
   //////////////////////////////
   assign hit_o   = valid_q[lookup_vpn_i];
   assign frame_o = frame_mem[lookup_vpn_i];  // only meaningful on hit

   //////////////////////////////
   // allocation
   //////////////////////////////

   // frame store, written once per page on its first touch
   always_ff @(posedge clk_i) begin
      if (alloc_i) frame_mem[lookup_vpn_i] <= free_q;
   end

   // frames handed out strictly in order
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= '0;                  // nothing mapped
         free_q  <= frame_t'(FRAME_BASE);
      end else if (alloc_i) begin
         valid_q[lookup_vpn_i] <= 1'b1;
         free_q                <= free_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hawk_cpu_stall.sv
//////////////////////////////
// cpu request stall unit
// request queue held until init is done
// window check and page translation
// forward register towards the arbiter
//////////////////////////////
`default_nettype none

module hawk_cpu_stall (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           hawk_inactive_i,
   input  logic                           init_done_i,
   input  hacd_bus_pkg::mem_req_t         cpu_req_i,
   input  logic                           cpu_req_valid_i,
   output logic                           cpu_req_ready_o,
   output hacd_bus_pkg::mem_req_t         fwd_req_o,
   output logic                           fwd_valid_o,
   input  logic                           fwd_ready_i,
   output logic [hacd_cfg_pkg::VPN_W-1:0] lookup_vpn_o,
   input  logic                           hit_i,
   input  hacd_bus_pkg::frame_t           frame_i,
   output logic                           alloc_o
);

   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,   // looking at queue head
      ST_ALLOC,  // frame just allocated, table hits now
      ST_SEND    // translated request offered
   } state_e;

   state_e   state_q, state_d;
   mem_req_t head, xlat_req;
   logic     q_push, q_pop, q_full, q_empty;
   logic     rdy_en_q;  // keeps ready low through reset
   logic     go, head_rdy, in_window, need_alloc;

   hawk_fifo #(
      .item_t (mem_req_t),
      .DEPTH  (CPU_Q_DEPTH)
   ) u_cpu_q (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (q_push),
      .data_i   (cpu_req_i),
      .full_o   (q_full),
      .pop_i    (q_pop),
      .data_o   (head),
      .empty_o  (q_empty)
   );

   assign cpu_req_ready_o = rdy_en_q & ~q_full;
   assign q_push          = cpu_req_valid_i & cpu_req_ready_o;

   //////////////////////////////
   // window check / translation
   //////////////////////////////
   assign go           = hawk_inactive_i | init_done_i;  // inactive bypasses init
   assign head_rdy     = ~q_empty & go;
   assign in_window    = ~hawk_inactive_i & (head.addr[ADDR_W-1:PAGE_BITS+VPN_W] == '0);
   assign lookup_vpn_o = head.addr[PAGE_BITS +: VPN_W];
   assign need_alloc   = in_window & ~hit_i;  // first touch of this page

   always_comb begin
      xlat_req = head;
      if (in_window) xlat_req.addr = {frame_i, head.addr[PAGE_BITS-1:0]};  // offset kept
   end

   //////////////////////////////
   // fsm
   //////////////////////////////
   always_comb begin
      state_d = state_q;
      alloc_o = 1'b0;
      q_pop   = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (head_rdy && need_alloc) begin
               alloc_o = 1'b1;  // table takes next frame on this edge
               state_d = ST_ALLOC;
            end else if (head_rdy) begin
               q_pop   = 1'b1;
               state_d = ST_SEND;
            end
         end
         ST_ALLOC: begin
            q_pop   = 1'b1;     // lookup hits with the new frame
            state_d = ST_SEND;
         end
         ST_SEND: begin
            if (fwd_ready_i) state_d = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   assign fwd_valid_o = (state_q == ST_SEND);

   always_ff @(posedge clk_i) begin
      if (q_pop) fwd_req_o <= xlat_req;  // held stable until accepted
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= ST_IDLE;
         rdy_en_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         rdy_en_q <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hawk_fifo.sv
//////////////////////////////
// small synchronous fifo
// type parameter for the payload
// circular buffer with occupancy count
//////////////////////////////
`default_nettype none

module hawk_fifo #(
   parameter type         item_t = logic,
   parameter int unsigned DEPTH  = 2
) (
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  logic  push_i,
   input  item_t data_i,
   output logic  full_o,
   input  logic  pop_i,
   output item_t data_o,
   output logic  empty_o
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   item_t            mem_q [DEPTH];  // payload storage
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;            // occupancy
   logic             do_push, do_pop;

   assign full_o  = (cnt_q == CNT_W'(DEPTH));
   assign empty_o = (cnt_q == '0);
   assign data_o  = mem_q[rd_ptr_q];  // head of queue, read comb

   assign do_push = push_i & ~full_o;   // push on full dropped
   assign do_pop  = pop_i & ~empty_o;   // pop on empty dropped

   always_ff @(posedge clk_i) begin
      if (do_push) mem_q[wr_ptr_q] <= data_i;
   end

   // pointers wrap at DEPTH, not at a power of two
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
         else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hawk_list_init.sv
//////////////////////////////
// free-list init writer
// zero writes over the list region after reset
// counts write acks, flags done
//////////////////////////////
`default_nettype none

module hawk_list_init (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   hawk_inactive_i,
   output hacd_bus_pkg::mem_req_t req_o,
   output logic                   req_valid_o,
   input  logic                   req_ready_i,
   input  logic                   rsp_valid_i,
   output logic                   init_done_o
);

   import hacd_cfg_pkg::*;

   localparam int unsigned CNT_W = $clog2(LIST_LINES + 1);

   logic [CNT_W-1:0] line_cnt_q, line_cnt_d;  // writes issued
   logic [CNT_W-1:0] rsp_cnt_q, rsp_cnt_d;    // acks seen
   logic             valid_q, done_q;
   logic             issue;

   assign req_valid_o = valid_q;
   assign init_done_o = done_q;
   assign issue       = valid_q & req_ready_i;

   // line i goes to LIST_BASE + i*LINE_BYTES
   always_comb begin
      req_o.wr   = 1'b1;
      req_o.addr = LIST_BASE + ADDR_W'(line_cnt_q) * ADDR_W'(LINE_BYTES);
      req_o.data = '0;
   end

   assign line_cnt_d = line_cnt_q + CNT_W'(issue);
   assign rsp_cnt_d  = rsp_cnt_q + CNT_W'(rsp_valid_i && (rsp_cnt_q != CNT_W'(LIST_LINES)));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         line_cnt_q <= '0;
         rsp_cnt_q  <= '0;
         valid_q    <= 1'b0;  // first write one cycle after release
         done_q     <= 1'b0;
      end else begin
         line_cnt_q <= line_cnt_d;
         rsp_cnt_q  <= rsp_cnt_d;
         valid_q    <= ~hawk_inactive_i & (line_cnt_d != CNT_W'(LIST_LINES));
         // sticky, never set while inactive
         if (!hawk_inactive_i && (line_cnt_d == CNT_W'(LIST_LINES)) &&
             (rsp_cnt_d == CNT_W'(LIST_LINES))) begin
            done_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hawk_mc_arbiter.sv
//////////////////////////////
// memory port arbiter
// fixed priority, hawk over cpu
// source tag queue for in-order response steering
//////////////////////////////
`default_nettype none

module hawk_mc_arbiter (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   // hawk master
   input  hacd_bus_pkg::mem_req_t hawk_req_i,
   input  logic                   hawk_valid_i,
   output logic                   hawk_ready_o,
   output logic                   hawk_rsp_valid_o,
   // cpu master, from the stall unit
   input  hacd_bus_pkg::mem_req_t cpu_req_i,
   input  logic                   cpu_valid_i,
   output logic                   cpu_ready_o,
   // memory controller
   output hacd_bus_pkg::mem_req_t mc_req_o,
   output logic                   mc_req_valid_o,
   input  logic                   mc_req_ready_i,
   input  hacd_bus_pkg::mem_rsp_t mc_rsp_i,
   input  logic                   mc_rsp_valid_i,
   output logic                   mc_rsp_ready_o,
   // cpu response channel
   output hacd_bus_pkg::mem_rsp_t cpu_rsp_o,
   output logic                   cpu_rsp_valid_o,
   input  logic                   cpu_rsp_ready_i
);

   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   src_tag_t push_tag, head_tag;
   logic     tag_full, tag_empty, tag_push, tag_pop;
   logic     rsp_hawk, rsp_cpu;

   //////////////////////////////
   // request side
   //////////////////////////////
   assign mc_req_valid_o = (hawk_valid_i | cpu_valid_i) & ~tag_full;  // no room, no issue
   assign mc_req_o       = hawk_valid_i ? hawk_req_i : cpu_req_i;
   assign hawk_ready_o   = mc_req_ready_i & ~tag_full;
   assign cpu_ready_o    = mc_req_ready_i & ~tag_full & ~hawk_valid_i;

   assign push_tag = hawk_valid_i ? SRC_HAWK : SRC_CPU;
   assign tag_push = mc_req_valid_o & mc_req_ready_i;  // memory handshake

   hawk_fifo #(
      .item_t (src_tag_t),
      .DEPTH  (TAG_DEPTH)
   ) u_tag_q (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (tag_push),
      .data_i   (push_tag),
      .full_o   (tag_full),
      .pop_i    (tag_pop),
      .data_o   (head_tag),
      .empty_o  (tag_empty)
   );

   //////////////////////////////
   // response side
   //////////////////////////////
   assign rsp_hawk = ~tag_empty & (head_tag == SRC_HAWK);
   assign rsp_cpu  = ~tag_empty & (head_tag == SRC_CPU);

   assign mc_rsp_ready_o   = rsp_hawk | (rsp_cpu & cpu_rsp_ready_i);  // hawk never stalls
   assign cpu_rsp_o        = mc_rsp_i;
   assign cpu_rsp_valid_o  = mc_rsp_valid_i & rsp_cpu;
   assign hawk_rsp_valid_o = mc_rsp_valid_i & rsp_hawk;  // write ack pulse
   assign tag_pop          = mc_rsp_valid_i & mc_rsp_ready_o;

endmodule

`default_nettype wire

// File: list.f
hacd_cfg_pkg.sv
hacd_bus_pkg.sv
hawk_fifo.sv
hawk_att_table.sv
hawk_cpu_stall.sv
hawk_list_init.sv
hawk_mc_arbiter.sv
hacd_core.sv
tb_mc_model.sv
tb_hacd_core.sv

// File: tb_hacd_core.sv
//////////////////////////////
// testbench of the hawk traffic path
// cpu stimulus in two phases, active and inactive
// reference translation and memory
// assertion checks and watchdog
//////////////////////////////
`default_nettype none

module tb_hacd_core;

   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   localparam int N_OPS    = 40;                    // cpu requests per phase
   localparam int OP_BOUND = 40;                    // cycles allowed per transaction
   localparam int TXNS     = 2 * N_OPS + LIST_LINES;
   localparam int WATCHDOG = (TXNS + 32) * OP_BOUND * 10;

   typedef struct packed {
      logic              wr;    // write ack, data not checked
      logic [DATA_W-1:0] data;
   } exp_rsp_t;

   logic     clk = 1'b0;
   logic     arst_n, hawk_inactive;
   mem_req_t cpu_req, mc_req;
   mem_rsp_t cpu_rsp, mc_rsp;
   logic     cpu_req_valid, cpu_req_ready, cpu_rsp_valid;
   logic     cpu_rsp_ready = 1'b0;
   logic     mc_req_valid, mc_req_ready, mc_rsp_valid, mc_rsp_ready, init_done;

   //////////////////////////////
   // reference state
   //////////////////////////////
   frame_t            page_map [int];                 // vpn to frame, first touch
   logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];   // by translated address
   mem_req_t          exp_mc_q [$];                   // cpu traffic as memory sees it
   exp_rsp_t          exp_rsp_q [$];
   logic [ADDR_W-1:0] init_addr;                      // next free-list line expected
   int                init_seen, n_checks, n_errors;
   logic              inactive_phase;
   string             test_name;

   hacd_core uut (
      .clk_i (clk), .arst_n_i (arst_n), .hawk_inactive_i (hawk_inactive),
      .cpu_req_i (cpu_req), .cpu_req_valid_i (cpu_req_valid), .cpu_req_ready_o (cpu_req_ready),
      .cpu_rsp_o (cpu_rsp), .cpu_rsp_valid_o (cpu_rsp_valid), .cpu_rsp_ready_i (cpu_rsp_ready),
      .mc_req_o (mc_req), .mc_req_valid_o (mc_req_valid), .mc_req_ready_i (mc_req_ready),
      .mc_rsp_i (mc_rsp), .mc_rsp_valid_i (mc_rsp_valid), .mc_rsp_ready_o (mc_rsp_ready),
      .init_done_o (init_done)
   );

   tb_mc_model u_mc (
      .clk_i (clk), .arst_n_i (arst_n),
      .req_i (mc_req), .req_valid_i (mc_req_valid), .req_ready_o (mc_req_ready),
      .rsp_o (mc_rsp), .rsp_valid_o (mc_rsp_valid), .rsp_ready_i (mc_rsp_ready)
   );

   always #5 clk = ~clk;

   // cpu side back-pressure
   always @(posedge clk) begin
      #1;
      cpu_rsp_ready = ($urandom_range(3) != 0);
   end

   task automatic compare_word(input string name, input logic [DATA_W-1:0] exp_v,
                               input logic [DATA_W-1:0] act_v);
      n_checks++;
      assert (exp_v === act_v) else begin
         n_errors++;
         $display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic require_true(input logic cond, input string what);
      n_checks++;
      assert (cond === 1'b1) else begin
         n_errors++;
         $display("error in %s: %s", test_name, what);
      end
   endtask

   // window pages get frames in first-touch order, offset kept
   function automatic logic [ADDR_W-1:0] expected_addr(input logic [ADDR_W-1:0] a);
      int vpn;
      if (inactive_phase || a[ADDR_W-1:PAGE_BITS+VPN_W] != '0) return a;
      vpn = int'(a[PAGE_BITS +: VPN_W]);
      if (!page_map.exists(vpn)) page_map[vpn] = frame_t'(FRAME_BASE + page_map.num());
      return {page_map[vpn], a[PAGE_BITS-1:0]};
   endfunction

   task automatic record_cpu_req();
      mem_req_t e;
      exp_rsp_t r;
      e      = cpu_req;
      e.addr = expected_addr(cpu_req.addr);
      r.wr   = cpu_req.wr;
      r.data = '0;
      if (cpu_req.wr) ref_mem[e.addr] = cpu_req.data;
      else if (ref_mem.exists(e.addr)) r.data = ref_mem[e.addr];
      exp_mc_q.push_back(e);
      exp_rsp_q.push_back(r);
   endtask

   task automatic score_mem_request();
      mem_req_t e;
      if (!inactive_phase && init_seen < int'(LIST_LINES)) begin
         require_true(mc_req.wr, "init request is not a write");
         compare_word($sformatf("%s init addr", test_name), DATA_W'(init_addr),
                      DATA_W'(mc_req.addr));
         compare_word($sformatf("%s init data", test_name), '0, mc_req.data);
         init_addr += ADDR_W'(LINE_BYTES);  // zero lines in order
         init_seen++;
      end else if (exp_mc_q.size() == 0) begin
         require_true(1'b0, "memory request with no cpu request outstanding");
      end else begin
         e = exp_mc_q.pop_front();
         if (!inactive_phase) require_true(init_done, "cpu request reached memory before init");
         compare_word($sformatf("%s mem addr", test_name), DATA_W'(e.addr), DATA_W'(mc_req.addr));
         compare_word($sformatf("%s mem wr", test_name), DATA_W'(e.wr), DATA_W'(mc_req.wr));
         if (e.wr) compare_word($sformatf("%s mem wdata", test_name), e.data, mc_req.data);
      end
   endtask

   task automatic score_cpu_response();
      exp_rsp_t r;
      if (exp_rsp_q.size() == 0) begin
         require_true(1'b0, "cpu response with no request outstanding");
      end else begin
         r = exp_rsp_q.pop_front();
         if (!r.wr) compare_word($sformatf("%s read data", test_name), r.data, cpu_rsp.data);
      end
   endtask

   //////////////////////////////
   // monitor, samples on the edge
   //////////////////////////////
   always @(posedge clk) begin
      if (!arst_n) begin
         require_true(!cpu_req_ready && !cpu_rsp_valid && !mc_req_valid && !init_done,
                      "outputs not low during reset");
      end else begin
         if (inactive_phase) require_true(!init_done, "init_done_o high while inactive");
         if (cpu_req_valid && cpu_req_ready) record_cpu_req();
         if (mc_req_valid && mc_req_ready) score_mem_request();
         if (cpu_rsp_valid && cpu_rsp_ready) score_cpu_response();
      end
   end

   // few pages for reuse, one in five outside the window
   function automatic mem_req_t random_req();
      mem_req_t          req;
      logic [ADDR_W-1:0] base;
      base     = ($urandom_range(4) == 0) ? 32'h0020_0000 : '0;
      req.wr   = ($urandom_range(1) == 1);
      req.addr = base + ADDR_W'($urandom_range(5)) * ADDR_W'(1 << PAGE_BITS)
                      + ADDR_W'($urandom_range(7) * LINE_BYTES);
      req.data = {$urandom, $urandom};
      return req;
   endfunction

   // called a step after the edge, returns a step after the handshake
   task automatic send_cpu_req(input mem_req_t req);
      cpu_req       = req;
      cpu_req_valid = 1'b1;
      do @(posedge clk); while (cpu_req_ready !== 1'b1);
      #1;
   endtask

   task automatic run_phase(input logic inactive, input string name);
      test_name      = name;
      arst_n         = 1'b0;
      hawk_inactive  = inactive;
      inactive_phase = inactive;
      init_seen      = 0;
      init_addr      = LIST_BASE;
      page_map.delete();
      repeat (8) @(posedge clk);
      #1 arst_n = 1'b1;
      for (int i = 0; i < N_OPS; i++) send_cpu_req(random_req());  // first ones while init runs
      cpu_req_valid = 1'b0;
      while (exp_rsp_q.size() != 0 || exp_mc_q.size() != 0) @(posedge clk);
      #1;
   endtask

   initial begin
      #(WATCHDOG);
      $display("watchdog expired after %0d time units, traffic did not drain", WATCHDOG);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      arst_n         = 1'b0;
      hawk_inactive  = 1'b0;
      cpu_req        = '0;
      cpu_req_valid  = 1'b0;
      inactive_phase = 1'b0;
      n_checks       = 0;
      n_errors       = 0;
      run_phase(1'b0, "active");
      compare_word("active init count", DATA_W'(LIST_LINES), DATA_W'(init_seen));
      require_true(init_done, "init_done_o low after the init writes");
      run_phase(1'b1, "inactive");
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) $display("** PASS **");
      else $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_mc_model.sv
//////////////////////////////
// memory controller model
// word store, in-order answers
// random ready and response gaps
//////////////////////////////
`default_nettype none

module tb_mc_model (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  hacd_bus_pkg::mem_req_t req_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   output hacd_bus_pkg::mem_rsp_t rsp_o,
   output logic                   rsp_valid_o,
   input  logic                   rsp_ready_i
);

   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   logic [DATA_W-1:0] store [logic [ADDR_W-1:0]];  // written words only
   mem_rsp_t          pend_q [$];                   // one answer per request
   mem_rsp_t          ans;
   logic              req_hs, rsp_hs, in_rst;

   initial begin
      void'($urandom(39635));  // single seed for the whole run
      req_ready_o = 1'b0;
      rsp_valid_o = 1'b0;
      rsp_o       = '0;
      forever begin
         @(posedge clk_i);
         in_rst = !arst_n_i;
         req_hs = req_valid_i & req_ready_o;
         rsp_hs = rsp_valid_o & rsp_ready_i;
         if (!in_rst && req_hs) begin
            ans.data = '0;  // write acks carry zero
            if (req_i.wr) store[req_i.addr] = req_i.data;
            else if (store.exists(req_i.addr)) ans.data = store[req_i.addr];
            pend_q.push_back(ans);
         end
         if (!in_rst && rsp_hs) void'(pend_q.pop_front());
         #1;
         if (in_rst) begin
            req_ready_o = 1'b0;
            rsp_valid_o = 1'b0;
            pend_q.delete();
         end else begin
            req_ready_o = ($urandom_range(3) != 0);  // about one stall in four
            // valid holds until taken
            if (!rsp_valid_o || rsp_hs) begin
               rsp_valid_o = (pend_q.size() != 0) && ($urandom_range(3) != 0);
               if (rsp_valid_o) rsp_o = pend_q[0];
            end
         end
      end
   end

endmodule

`default_nettype wire
